//--- common/sram_tester_pkg.sv
// sram_tester_pkg: shared enums and widths of the SRAM memory tester
`default_nettype none

package sram_tester_pkg;

  // Test selected by the start pulse
  typedef enum logic [1:0] {
    MODE_CHECKER  = 2'd0,
    MODE_ADDR     = 2'd1,
    MODE_ADDR_INV = 2'd2,
    MODE_MARCH    = 2'd3
  } test_mode_e;

  // Operation applied to every address of one pass
  typedef enum logic [1:0] {
    OP_WRITE = 2'd0,
    OP_READ  = 2'd1,
    // Read expected pattern, then write its complement
    OP_RW    = 2'd2
  } pass_op_e;

  // Data pattern of a pass, derived from the address where needed
  typedef enum logic [2:0] {
    PAT_CHECKER  = 3'd0,
    PAT_ADDR     = 3'd1,
    PAT_ADDR_INV = 3'd2,
    PAT_ZERO     = 3'd3,
    PAT_ONES     = 3'd4
  } pattern_e;

  // Chip cycle phases of the SRAM controller
  typedef enum logic [1:0] {
    CS_IDLE   = 2'd0,
    CS_SETUP  = 2'd1,
    CS_STROBE = 2'd2,
    CS_HOLD   = 2'd3
  } ctrl_state_e;

  // Error counter width
  localparam int ERR_BITS = 16;

endpackage

`default_nettype wire

//--- common/sram_pass_if.sv
// sram_pass_if: one pass descriptor handed from test decode to test engine
`timescale 1ns/1ps
`default_nettype none

interface sram_pass_if;
  import sram_tester_pkg::*;

  // Pulse that launches the pass
  logic     pass_start;
  pass_op_e pass_op;
  pattern_e pass_pat;
  // Set on the final pass of the selected mode
  logic     pass_last;
  // Pulse after the last address of the pass was acknowledged
  logic     pass_done;

  modport src (
    output pass_start,
    output pass_op,
    output pass_pat,
    output pass_last,
    input  pass_done
  );

  modport dst (
    input  pass_start,
    input  pass_op,
    input  pass_pat,
    input  pass_last,
    output pass_done
  );

endinterface

`default_nettype wire

//--- common/sram_bus_if.sv
// sram_bus_if: single SRAM accesses plus read check records inside the tester
`timescale 1ns/1ps
`default_nettype none

interface sram_bus_if #(
  parameter int ADDR_BITS = 10,
  parameter int DATA_BITS = 8
);

  // Access request, one open at a time
  logic                 req;
  logic                 we;
  logic [ADDR_BITS-1:0] addr;
  logic [DATA_BITS-1:0] wdata;
  // Ack pulse, rdata valid with it on reads
  logic                 ack;
  logic [DATA_BITS-1:0] rdata;

  // Check record of one completed read
  logic                 chk_valid;
  logic [ADDR_BITS-1:0] chk_addr;
  logic [DATA_BITS-1:0] chk_expected;
  logic [DATA_BITS-1:0] chk_actual;

  modport master (output req, we, addr, wdata, input ack, rdata);

  modport slave (input req, we, addr, wdata, output ack, rdata);

  modport chk_src (output chk_valid, chk_addr, chk_expected, chk_actual);

  modport chk_dst (input chk_valid, chk_addr, chk_expected, chk_actual);

endinterface

`default_nettype wire

//--- verilog/test_decode.sv
// test_decode: expands the latched test mode into its passes and issues them in order
`timescale 1ns/1ps
`default_nettype none

module test_decode (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic                        start,
  input  sram_tester_pkg::test_mode_e mode,
  output logic                        busy,
  sram_pass_if.src                    pass,
  output logic                        run_done
);
  import sram_tester_pkg::*;

  test_mode_e mode_q;
  logic [1:0] pass_idx;
  logic       start_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      busy     <= 1'b0;
      mode_q   <= MODE_CHECKER;
      pass_idx <= 2'd0;
      start_q  <= 1'b0;
      run_done <= 1'b0;
    end else begin
      start_q  <= 1'b0;
      run_done <= 1'b0;
      // Start only counts while idle
      if (start && !busy) begin
        busy     <= 1'b1;
        mode_q   <= mode;
        pass_idx <= 2'd0;
        start_q  <= 1'b1;
      end else if (run_done) begin
        // busy falls together with the delayed done
        busy <= 1'b0;
      end else if (pass.pass_done) begin
        if (pass.pass_last) begin
          run_done <= 1'b1;
        end else begin
          pass_idx <= pass_idx + 2'd1;
          start_q  <= 1'b1;
        end
      end
    end
  end

  assign pass.pass_start = start_q;

  // Pass table, write first then read back
  always_comb begin
    pass.pass_op   = (pass_idx == 2'd0) ? OP_WRITE : OP_READ;
    pass.pass_last = (pass_idx == 2'd1);
    unique case (mode_q)
      MODE_CHECKER:  pass.pass_pat = PAT_CHECKER;
      MODE_ADDR:     pass.pass_pat = PAT_ADDR;
      MODE_ADDR_INV: pass.pass_pat = PAT_ADDR_INV;
      MODE_MARCH: begin
        // Zeros, read zeros and write ones, read ones
        pass.pass_last = (pass_idx == 2'd2);
        if (pass_idx == 2'd1) begin
          pass.pass_op = OP_RW;
        end
        pass.pass_pat = (pass_idx == 2'd2) ? PAT_ONES : PAT_ZERO;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/test_engine.sv
// test_engine: walks the address window per pass, issues accesses and emits check records
`timescale 1ns/1ps
`default_nettype none

module test_engine #(
  parameter int ADDR_BITS = 10,
  parameter int DATA_BITS = 8
) (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 start,
  input  logic [ADDR_BITS-1:0] base_addr,
  input  logic [ADDR_BITS:0]   length,
  sram_pass_if.dst             pass,
  sram_bus_if.master           bus,
  sram_bus_if.chk_src          chk
);
  import sram_tester_pkg::*;

  typedef enum logic {EN_IDLE, EN_WAIT} eng_state_e;

  eng_state_e           state;
  logic [ADDR_BITS-1:0] base_q;
  logic [ADDR_BITS-1:0] addr_q;
  logic [ADDR_BITS-1:0] next_addr;
  logic [ADDR_BITS:0]   len_q;
  logic [ADDR_BITS:0]   left_q;
  logic                 req_q;
  logic                 we_q;
  logic                 rw_phase;
  logic                 rw_turn;
  logic                 done_q;
  logic                 chk_q;
  logic [DATA_BITS-1:0] wdata_q;
  logic [ADDR_BITS-1:0] chk_addr_q;
  logic [DATA_BITS-1:0] exp_q;
  logic [DATA_BITS-1:0] act_q;

  // Pattern value of one address
  function automatic logic [DATA_BITS-1:0] pat_data(input pattern_e pat,
                                                    input logic [ADDR_BITS-1:0] a);
    logic [ADDR_BITS+DATA_BITS-1:0] a_ext;
    logic [DATA_BITS-1:0]           d;
    a_ext = {{DATA_BITS{1'b0}}, a};
    d     = '0;
    case (pat)
      // 0x55 on even, 0xAA on odd addresses
      PAT_CHECKER: for (int i = 0; i < DATA_BITS; i++) d[i] = (i % 2 == 0) ? ~a[0] : a[0];
      PAT_ADDR:     d = a_ext[DATA_BITS-1:0];
      PAT_ADDR_INV: d = ~a_ext[DATA_BITS-1:0];
      PAT_ONES:     d = '1;
      default:      d = '0;
    endcase
    return d;
  endfunction

  assign next_addr = addr_q + 1'b1;
  // Read half of a read-write just finished, write goes to the same address
  assign rw_turn   = (pass.pass_op == OP_RW) && !rw_phase;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= EN_IDLE;
      req_q    <= 1'b0;
      we_q     <= 1'b0;
      rw_phase <= 1'b0;
      left_q   <= '0;
      done_q   <= 1'b0;
      chk_q    <= 1'b0;
    end else begin
      req_q  <= 1'b0;
      done_q <= 1'b0;
      chk_q  <= 1'b0;
      case (state)
        EN_IDLE: if (pass.pass_start) begin
          state    <= EN_WAIT;
          req_q    <= 1'b1;
          we_q     <= (pass.pass_op == OP_WRITE);
          rw_phase <= 1'b0;
          left_q   <= len_q;
        end
        EN_WAIT: if (bus.ack) begin
          // Every read ack yields a check record
          chk_q <= !we_q;
          if (rw_turn) begin
            rw_phase <= 1'b1;
            req_q    <= 1'b1;
            we_q     <= 1'b1;
          end else if (left_q == (ADDR_BITS+1)'(1)) begin
            state  <= EN_IDLE;
            done_q <= 1'b1;
          end else begin
            left_q   <= left_q - 1'b1;
            rw_phase <= 1'b0;
            req_q    <= 1'b1;
            we_q     <= (pass.pass_op == OP_WRITE);
          end
        end
        default: state <= EN_IDLE;
      endcase
    end
  end

  // Window, address, write data and check payload
  always_ff @(posedge clk) begin
    if (start) begin
      base_q <= base_addr;
      len_q  <= length;
    end
    if (state == EN_IDLE && pass.pass_start) begin
      addr_q  <= base_q;
      wdata_q <= pat_data(pass.pass_pat, base_q);
    end else if (state == EN_WAIT && bus.ack) begin
      if (!we_q) begin
        chk_addr_q <= addr_q;
        exp_q      <= pat_data(pass.pass_pat, addr_q);
        act_q      <= bus.rdata;
      end
      if (rw_turn) begin
        wdata_q <= ~pat_data(pass.pass_pat, addr_q);
      end else begin
        addr_q  <= next_addr;
        wdata_q <= pat_data(pass.pass_pat, next_addr);
      end
    end
  end

  assign bus.req          = req_q;
  assign bus.we           = we_q;
  assign bus.addr         = addr_q;
  assign bus.wdata        = wdata_q;
  assign pass.pass_done   = done_q;
  assign chk.chk_valid    = chk_q;
  assign chk.chk_addr     = chk_addr_q;
  assign chk.chk_expected = exp_q;
  assign chk.chk_actual   = act_q;

endmodule

`default_nettype wire

//--- sram_ctrl/sram_ctrl.sv
// sram_ctrl: runs fixed multi-cycle read and write cycles on the asynchronous SRAM pins
`timescale 1ns/1ps
`default_nettype none

module sram_ctrl #(
  parameter int ADDR_BITS = 10,
  parameter int DATA_BITS = 8
) (
  input  logic                 clk,
  input  logic                 arst_n,
  sram_bus_if.slave            bus,
  output logic [ADDR_BITS-1:0] sram_addr,
  inout  wire  [DATA_BITS-1:0] sram_data,
  output logic                 sram_we_n,
  output logic                 sram_oe_n,
  output logic                 sram_ce_n
);
  import sram_tester_pkg::*;

  ctrl_state_e          state;
  // Access in flight is a write
  logic                 wr_q;
  logic                 ack_q;
  logic [DATA_BITS-1:0] wdata_q;
  logic [DATA_BITS-1:0] rdata_q;
  logic                 drive_en;

  // Write cycle  req, SETUP, STROBE, HOLD, ack
  // Read cycle   req, SETUP, STROBE, ack
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= CS_IDLE;
      wr_q      <= 1'b0;
      ack_q     <= 1'b0;
      sram_ce_n <= 1'b1;
      sram_we_n <= 1'b1;
      sram_oe_n <= 1'b1;
    end else begin
      ack_q <= 1'b0;
      case (state)
        CS_IDLE: if (bus.req) begin
          state     <= CS_SETUP;
          wr_q      <= bus.we;
          sram_ce_n <= 1'b0;
          // Output enable only for reads
          sram_oe_n <= bus.we;
        end
        CS_SETUP: begin
          state     <= CS_STROBE;
          sram_we_n <= !wr_q;
        end
        CS_STROBE: begin
          if (wr_q) begin
            // Release WE, data stays on the bus one more cycle
            state     <= CS_HOLD;
            sram_we_n <= 1'b1;
          end else begin
            state     <= CS_IDLE;
            ack_q     <= 1'b1;
            sram_ce_n <= 1'b1;
            sram_oe_n <= 1'b1;
          end
        end
        CS_HOLD: begin
          state     <= CS_IDLE;
          ack_q     <= 1'b1;
          sram_ce_n <= 1'b1;
        end
        default: state <= CS_IDLE;
      endcase
    end
  end

  // Address and write data held for the whole cycle
  always_ff @(posedge clk) begin
    if (state == CS_IDLE && bus.req) begin
      sram_addr <= bus.addr;
      wdata_q   <= bus.wdata;
    end
    // Sample on the edge that ends the read strobe
    if (state == CS_STROBE && !wr_q) begin
      rdata_q <= sram_data;
    end
  end

  // Chip data bus is ours only during write states
  assign drive_en  = wr_q && (state != CS_IDLE);
  assign sram_data = drive_en ? wdata_q : {DATA_BITS{1'bz}};

  assign bus.ack   = ack_q;
  assign bus.rdata = rdata_q;

endmodule

`default_nettype wire

//--- verilog/result_check.sv
// result_check: compares read data with expected, counts errors and keeps the first failing address
`timescale 1ns/1ps
`default_nettype none

module result_check #(
  parameter int ADDR_BITS = 10
) (
  input  logic                                clk,
  input  logic                                arst_n,
  input  logic                                start,
  sram_bus_if.chk_dst                         chk,
  input  logic                                run_done,
  output logic [sram_tester_pkg::ERR_BITS-1:0] error_count,
  output logic [ADDR_BITS-1:0]                first_fail_addr,
  output logic                                fail_seen,
  output logic                                done
);
  import sram_tester_pkg::*;

  logic mismatch;

  assign mismatch = chk.chk_valid && (chk.chk_actual != chk.chk_expected);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      error_count     <= '0;
      first_fail_addr <= '0;
      fail_seen       <= 1'b0;
      done            <= 1'b0;
    end else begin
      // One cycle late so the final record is already counted
      done <= run_done;
      if (start) begin
        error_count     <= '0;
        first_fail_addr <= '0;
        fail_seen       <= 1'b0;
      end else if (mismatch) begin
        // Saturate at all ones
        if (error_count != {ERR_BITS{1'b1}}) begin
          error_count <= error_count + 1'b1;
        end
        if (!fail_seen) begin
          first_fail_addr <= chk.chk_addr;
          fail_seen       <= 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/sram_tester.sv
// sram_tester: SRAM memory tester top, decode, engine, chip controller and result check
`timescale 1ns/1ps
`default_nettype none

module sram_tester #(
  parameter int ADDR_BITS = 10,
  parameter int DATA_BITS = 8
) (
  input  logic                                clk,
  input  logic                                arst_n,
  input  logic                                start,
  input  logic [1:0]                          mode,
  input  logic [ADDR_BITS-1:0]                base_addr,
  input  logic [ADDR_BITS:0]                  length,
  output logic                                busy,
  output logic                                done,
  output logic [sram_tester_pkg::ERR_BITS-1:0] error_count,
  output logic [ADDR_BITS-1:0]                first_fail_addr,
  output logic                                fail_seen,
  output logic [ADDR_BITS-1:0]                sram_addr,
  inout  wire  [DATA_BITS-1:0]                sram_data,
  output logic                                sram_we_n,
  output logic                                sram_oe_n,
  output logic                                sram_ce_n
);
  import sram_tester_pkg::*;

  logic run_start;
  logic run_done;

  sram_pass_if pass_if ();
  sram_bus_if #(.ADDR_BITS(ADDR_BITS), .DATA_BITS(DATA_BITS)) bus_if ();

  // Start accepted only while idle, shared by engine and result
  assign run_start = start && !busy;

  test_decode u_decode (
    .clk, .arst_n, .start,
    .mode     (test_mode_e'(mode)),
    .busy, .pass(pass_if), .run_done
  );

  test_engine #(.ADDR_BITS(ADDR_BITS), .DATA_BITS(DATA_BITS)) u_engine (
    .clk, .arst_n, .start(run_start), .base_addr, .length,
    .pass(pass_if), .bus(bus_if), .chk(bus_if)
  );

  sram_ctrl #(.ADDR_BITS(ADDR_BITS), .DATA_BITS(DATA_BITS)) u_ctrl (
    .clk, .arst_n, .bus(bus_if),
    .sram_addr, .sram_data, .sram_we_n, .sram_oe_n, .sram_ce_n
  );

  result_check #(.ADDR_BITS(ADDR_BITS)) u_result (
    .clk, .arst_n, .start(run_start), .chk(bus_if), .run_done,
    .error_count, .first_fail_addr, .fail_seen, .done
  );

endmodule

`default_nettype wire

//--- verif/sram_model.sv
// sram_model: asynchronous SRAM chip model with access-time checks and a stuck-at-ones cell
`timescale 1ns/1ps
`default_nettype none

module sram_model #(
  parameter int ADDR_BITS    = 10,
  parameter int DATA_BITS    = 8,
  parameter bit INJECT_ERROR = 1'b0,
  parameter int FAULT_ADDR   = 255,
  // Chip timing in ns
  parameter int T_AA         = 25,
  parameter int T_WP         = 40,
  parameter int T_DS         = 20
) (
  input  wire  [ADDR_BITS-1:0] addr,
  inout  wire  [DATA_BITS-1:0] data,
  input  wire                  we_n,
  input  wire                  oe_n,
  input  wire                  ce_n,
  output int                   viol_count
);

  logic [DATA_BITS-1:0] mem [2**ADDR_BITS];
  logic [DATA_BITS-1:0] dout;
  logic                 rd_en;
  realtime              addr_t;
  realtime              data_t;
  realtime              we_fall_t;

  initial begin
    viol_count = 0;
    addr_t     = 0.0;
    data_t     = 0.0;
    we_fall_t  = 0.0;
  end

  // Output buffer on only for a selected, output-enabled read
  assign rd_en = !ce_n && !oe_n && we_n;
  assign data  = rd_en ? dout : {DATA_BITS{1'bz}};

  // Faulty cell always reads as all ones
  function automatic logic [DATA_BITS-1:0] read_word(input logic [ADDR_BITS-1:0] a);
    if (INJECT_ERROR && a == ADDR_BITS'(FAULT_ADDR)) begin
      return {DATA_BITS{1'b1}};
    end
    return mem[a];
  endfunction

  task automatic violation(input string msg);
    viol_count++;
    $display("sram_model: %s at %0t", msg, $realtime);
  endtask

  always @(addr) addr_t = $realtime;
  always @(data) data_t = $realtime;

  // Read data unknown until the access time has passed
  always @(addr or rd_en) begin
    if (rd_en) begin
      dout = 'x;
      dout <= #(T_AA) read_word(addr);
    end
  end

  always @(negedge we_n) begin
    if (!ce_n) begin
      we_fall_t = $realtime;
    end
    if (!oe_n) begin
      violation("write enable and output enable low together");
    end
  end

  // Write takes place at the end of the WE pulse
  always @(posedge we_n) begin
    if (ce_n === 1'b0) begin
      if ($realtime - we_fall_t < T_WP) begin
        violation("write pulse shorter than the minimum width");
      end
      if ($realtime - data_t < T_DS) begin
        violation("write data not settled before the end of the pulse");
      end
      if (addr_t > we_fall_t) begin
        violation("address changed during the write pulse");
      end
      if ($isunknown(data) || $isunknown(addr)) begin
        violation("write with unknown address or data");
      end
      mem[addr] = data;
    end
  end

endmodule

`default_nettype wire

//--- verif/tb_sram_tester_props.sv
// tb_sram_tester_props: concurrent assertions on the SRAM pins and the chip controller FSM
`timescale 1ns/1ps
`default_nettype none

module tb_sram_tester_props (
  input logic                         clk,
  input logic                         arst_n,
  input sram_tester_pkg::ctrl_state_e state,
  input logic                         drive_en,
  input logic                         req,
  input logic                         ack,
  input logic                         sram_we_n,
  input logic                         sram_oe_n,
  input logic                         sram_ce_n
);
  import sram_tester_pkg::*;

  int fail_cnt = 0;

  // Chip never sees write and output enable at once
  we_oe_excl: assert property (@(posedge clk) disable iff (!arst_n)
    !(!sram_we_n && !sram_oe_n))
    else begin
      fail_cnt++;
      $error("write enable and output enable are low together");
    end

  // Data driver only around the write strobe
  drive_window: assert property (@(posedge clk) disable iff (!arst_n)
    drive_en |-> (!sram_we_n || state == CS_SETUP || state == CS_HOLD))
    else begin
      fail_cnt++;
      $error("data bus driven outside a write cycle");
    end

  req_to_ack: assert property (@(posedge clk) disable iff (!arst_n)
    req |-> ##[1:4] ack)
    else begin
      fail_cnt++;
      $error("request not acknowledged within four cycles");
    end

  idle_ce_high: assert property (@(posedge clk) disable iff (!arst_n)
    (state == CS_IDLE) |-> sram_ce_n)
    else begin
      fail_cnt++;
      $error("chip enable low while the controller is idle");
    end

endmodule

`default_nettype wire

//--- verif/tb_checker.sv
// Testbench checker that watches the tester outputs and compares results with the reference at done
`timescale 1ns/1ps
`default_nettype none

module tb_checker #(
  parameter int ADDR_BITS = 10
) (
  input  logic                                clk,
  input  logic                                arst_n,
  input  logic                                busy,
  input  logic                                done,
  input  logic [sram_tester_pkg::ERR_BITS-1:0] error_count,
  input  logic [ADDR_BITS-1:0]                first_fail_addr,
  input  logic                                fail_seen,
  input  logic                                sram_we_n,
  input  logic                                sram_oe_n,
  input  logic                                sram_ce_n,
  input  logic                                idle_watch,
  input  logic                                armed,
  input  int                                  exp_count,
  input  int                                  exp_addr,
  input  logic                                exp_fail,
  output int                                  err_count,
  output int                                  check_count
);
  import sram_tester_pkg::*;

  int   dones;
  int   held_count;
  int   held_addr;
  logic held_fail;
  logic armed_q;

  initial begin
    err_count   = 0;
    check_count = 0;
    dones       = 0;
    armed_q     = 1'b0;
  end

  task automatic compare_results();
    check_count++;
    if (int'(error_count) != exp_count) begin
      err_count++;
      $display("[FAIL] %0t: error_count %0d, expected %0d", $time, error_count, exp_count);
    end
    if (int'(first_fail_addr) != exp_addr) begin
      err_count++;
      $display("[FAIL] %0t: first_fail_addr %0d, expected %0d", $time, first_fail_addr,
               exp_addr);
    end
    if (fail_seen !== exp_fail) begin
      err_count++;
      $display("[FAIL] %0t: fail_seen %0b, expected %0b", $time, fail_seen, exp_fail);
    end
    if (busy !== 1'b0) begin
      err_count++;
      $display("[FAIL] %0t: busy %0b with done, expected 0", $time, busy);
    end
    held_count = int'(error_count);
    held_addr  = int'(first_fail_addr);
    held_fail  = fail_seen;
  endtask

  // Outputs settle well before the falling edge
  always @(negedge clk) begin
    if (arst_n) begin
      if (idle_watch && (busy || done || fail_seen || !sram_ce_n || !sram_we_n || !sram_oe_n)) begin
        err_count++;
        $display("[FAIL] %0t: idle with busy %0b done %0b fail %0b ce_n %0b we_n %0b oe_n %0b",
                 $time, busy, done, fail_seen, sram_ce_n, sram_we_n, sram_oe_n);
      end
      // Count done pulses afresh for each new run
      if (armed && !armed_q) begin
        dones = 0;
      end
      armed_q = armed;
      if (done) begin
        if (!armed) begin
          err_count++;
          $display("Done pulsed with no run in progress at %0t", $time);
        end else begin
          dones++;
          if (dones > 1) begin
            err_count++;
            $display("More than one done for a single run at %0t", $time);
          end else begin
            compare_results();
          end
        end
      end else if (armed && dones == 1) begin
        // Results hold until the next start
        if (int'(error_count) != held_count || int'(first_fail_addr) != held_addr ||
            fail_seen !== held_fail) begin
          err_count++;
          $display("[FAIL] %0t: results changed after done", $time);
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- verif/tb_sram_tester.sv
// tb_sram_tester: testbench for the SRAM tester with chip model, reference and random runs
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD       = 100,
  parameter int RESET_CYCLES = 4
) (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // Reset released shortly after an edge
  initial begin
    arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #5;
    arst_n = 1'b1;
  end

endmodule

module tb_sram_tester;
  import sram_tester_pkg::*;

  localparam int ADDR_BITS     = 10;
  localparam int DATA_BITS     = 8;
  localparam int DEPTH         = 1 << ADDR_BITS;
  localparam int FAULT_ADDR    = 255;
  localparam int DONE_TIMEOUT  = 60000;
  localparam int RESET_TIMEOUT = 20;

  logic                 clk;
  logic                 arst_n;
  logic                 start;
  logic [1:0]           mode;
  logic [ADDR_BITS-1:0] base_addr;
  logic [ADDR_BITS:0]   length;
  logic                 busy;
  logic                 done;
  logic [ERR_BITS-1:0]  error_count;
  logic [ADDR_BITS-1:0] first_fail_addr;
  logic                 fail_seen;
  logic [ADDR_BITS-1:0] sram_addr;
  wire  [DATA_BITS-1:0] sram_data;
  logic                 sram_we_n;
  logic                 sram_oe_n;
  logic                 sram_ce_n;

  // Expected results handed to the checker
  logic idle_watch;
  logic armed;
  int   exp_count;
  int   exp_addr;
  logic exp_fail;
  int   chk_errors;
  int   check_count;
  int   model_viol;
  int   timeouts;
  bit   abort;

  tb_clock_gen #(.PERIOD(100), .RESET_CYCLES(4)) clk_gen (.clk, .arst_n);

  sram_tester #(.ADDR_BITS(ADDR_BITS), .DATA_BITS(DATA_BITS)) dut0 (
    .clk, .arst_n, .start, .mode, .base_addr, .length,
    .busy, .done, .error_count, .first_fail_addr, .fail_seen,
    .sram_addr, .sram_data, .sram_we_n, .sram_oe_n, .sram_ce_n
  );

  sram_model #(.ADDR_BITS(ADDR_BITS), .DATA_BITS(DATA_BITS), .INJECT_ERROR(1'b1)) chip0 (
    .addr(sram_addr), .data(sram_data), .we_n(sram_we_n), .oe_n(sram_oe_n),
    .ce_n(sram_ce_n), .viol_count(model_viol)
  );

  tb_checker #(.ADDR_BITS(ADDR_BITS)) checker0 (
    .clk, .arst_n, .busy, .done, .error_count, .first_fail_addr, .fail_seen,
    .sram_we_n, .sram_oe_n, .sram_ce_n, .idle_watch, .armed,
    .exp_count, .exp_addr, .exp_fail, .err_count(chk_errors), .check_count
  );

  bind sram_ctrl tb_sram_tester_props props0 (
    .clk(clk), .arst_n(arst_n), .state(state), .drive_en(drive_en),
    .req(bus.req), .ack(bus.ack),
    .sram_we_n(sram_we_n), .sram_oe_n(sram_oe_n), .sram_ce_n(sram_ce_n)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Data a pass puts at one address
  function automatic logic [DATA_BITS-1:0] pattern_value(input pattern_e pat, input int a);
    logic [DATA_BITS-1:0] low;
    low = a[DATA_BITS-1:0];
    case (pat)
      PAT_CHECKER:  return (a % 2 == 1) ? 8'hAA : 8'h55;
      PAT_ADDR:     return low;
      PAT_ADDR_INV: return ~low;
      PAT_ONES:     return 8'hFF;
      default:      return 8'h00;
    endcase
  endfunction

  // Only the faulty cell misreads, always as 0xFF
  function automatic void expected_result(input test_mode_e m, input int base, input int len,
                                          output int count, output int fail_addr);
    pattern_e reads[$];
    count     = 0;
    fail_addr = 0;
    case (m)
      MODE_CHECKER:  reads.push_back(PAT_CHECKER);
      MODE_ADDR:     reads.push_back(PAT_ADDR);
      MODE_ADDR_INV: reads.push_back(PAT_ADDR_INV);
      default: begin
        reads.push_back(PAT_ZERO);
        reads.push_back(PAT_ONES);
      end
    endcase
    if (base <= FAULT_ADDR && FAULT_ADDR < base + len) begin
      foreach (reads[i]) begin
        if (pattern_value(reads[i], FAULT_ADDR) != 8'hFF) begin
          count++;
        end
      end
    end
    if (count > 0) begin
      fail_addr = FAULT_ADDR;
    end
  endfunction

  task automatic wait_done();
    int cycles;
    bit got;
    cycles = 0;
    got    = 1'b0;
    while (!got && cycles < DONE_TIMEOUT) begin
      @(negedge clk);
      got = done;
      cycles++;
    end
    if (!got) begin
      timeouts++;
      abort = 1'b1;
      $display("Timeout: no done within %0d cycles at %0t", DONE_TIMEOUT, $time);
    end
  endtask

  // One run, optionally with a stray start while busy
  task automatic run_test(input test_mode_e m, input int base, input int len, input bit restart);
    int cnt;
    int faddr;
    if (abort) return;
    expected_result(m, base, len, cnt, faddr);
    @(posedge clk);
    #5;
    exp_count = cnt;
    exp_addr  = faddr;
    exp_fail  = (cnt > 0);
    mode      = m;
    base_addr = ADDR_BITS'(base);
    length    = (ADDR_BITS+1)'(len);
    start     = 1'b1;
    armed     = 1'b1;
    @(posedge clk);
    #5;
    start = 1'b0;
    if (restart) begin
      repeat (3) @(posedge clk);
      #5;
      mode      = MODE_CHECKER;
      base_addr = '0;
      length    = (ADDR_BITS+1)'(5);
      start     = 1'b1;
      @(posedge clk);
      #5;
      start = 1'b0;
    end
    wait_done();
    // Window for a stray second done
    repeat (20) @(posedge clk);
    #5;
    armed = 1'b0;
  endtask

  initial begin
    logic [31:0] seed;
    int          rl;
    int          rb;
    int          cycles;
    test_mode_e  rm;
    start      = 1'b0;
    mode       = 2'd0;
    base_addr  = '0;
    length     = '0;
    idle_watch = 1'b1;
    armed      = 1'b0;
    exp_count  = 0;
    exp_addr   = 0;
    exp_fail   = 1'b0;
    timeouts   = 0;
    abort      = 1'b0;
    cycles     = 0;
    while (!arst_n && cycles < RESET_TIMEOUT) begin
      @(posedge clk);
      cycles++;
    end
    if (!arst_n) begin
      timeouts++;
      abort = 1'b1;
      $display("Timeout: reset never released");
    end
    // Quiet tester after reset
    repeat (10) @(posedge clk);
    #5;
    idle_watch = 1'b0;
    // Windows clear of the faulty cell
    for (int m = 0; m < 4; m++) run_test(test_mode_e'(m), 300, 40, 1'b0);
    // Windows across the faulty cell
    for (int m = 0; m < 4; m++) run_test(test_mode_e'(m), 240, 32, 1'b0);
    run_test(MODE_MARCH, 250, 10, 1'b1);
    seed = 32'h70e;
    for (int i = 0; i < 30; i++) begin
      seed = lcg_next(seed);
      rm   = test_mode_e'(seed[17:16]);
      seed = lcg_next(seed);
      rl   = 1 + int'(seed[25:16]);
      if (i == 0) rl = 1;
      if (i == 1) rl = DEPTH;
      seed = lcg_next(seed);
      rb   = int'(seed[31:16]) % (DEPTH - rl + 1);
      run_test(rm, rb, rl, 1'b0);
    end
    repeat (5) @(posedge clk);
    $display("Runs checked %0d, errors %0d, timeouts %0d, model violations %0d, assertion failures %0d",
             check_count, chk_errors, timeouts, model_viol, dut0.u_ctrl.props0.fail_cnt);
    if (chk_errors == 0 && timeouts == 0 && model_viol == 0 &&
        dut0.u_ctrl.props0.fail_cnt == 0 && check_count > 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sram_tester.f
common/sram_tester_pkg.sv
common/sram_pass_if.sv
common/sram_bus_if.sv
verilog/test_decode.sv
verilog/test_engine.sv
sram_ctrl/sram_ctrl.sv
verilog/result_check.sv
verilog/sram_tester.sv
verif/sram_model.sv
verif/tb_sram_tester_props.sv
verif/tb_checker.sv
verif/tb_sram_tester.sv

//--- Bender.yml
package:
  name: sram_tester

sources:
  - common/sram_tester_pkg.sv
  - common/sram_pass_if.sv
  - common/sram_bus_if.sv
  - verilog/test_decode.sv
  - verilog/test_engine.sv
  - sram_ctrl/sram_ctrl.sv
  - verilog/result_check.sv
  - verilog/sram_tester.sv
  - target: test
    files:
      - verif/sram_model.sv
      - verif/tb_sram_tester_props.sv
      - verif/tb_checker.sv
      - verif/tb_sram_tester.sv
